//--- files.f
gc_pkg.sv
gc_config.sv
netlist_store.sv
label_gen.sv
label_ram.sv
garble_ctrl.sv
gc_top.sv
gc_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = gc_tb
FILELIST = files.f
OBJ = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qx "NO ERRORS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ) $(LOG)

//--- gc_tb.sv
// Testbench for the garbling engine. Loads netlists, starts runs with a seed
// and checks the tagged stream against a reference model of the same rules.
`timescale 1ns/10ps

module gc_tb import gc_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000; // 4 runs of 3*64+32+10 plus netlist loads

	logic clk, rst, start;
	logic [LABEL_W-1:0] seed;
	logic cfg_wr_en;
	logic [1:0] cfg_addr;
	logic [WIRE_W-1:0] cfg_data;
	logic nl_wr_en;
	logic [GATE_W-1:0] nl_wr_addr;
	gate_op_t nl_wr_op;
	logic [WIRE_W-1:0] nl_wr_in0, nl_wr_in1;
	logic busy;
	tag_t tag;
	logic [WIRE_W-1:0] index;
	logic [LABEL_W-1:0] data;

	integer seed_var = 32'hacb0_795f;
	int n_in, n_gates, n_out;
	gate_op_t tb_op [128];
	int tb_in0 [128];
	int tb_in1 [128];
	tag_t exp_tag [$];
	logic [WIRE_W-1:0] exp_idx [$];
	logic [LABEL_W-1:0] exp_data [$];
	int err_count = 0;
	int word_count = 0;
	int test_count = 0;
	int cycles = 0;
	bit mask_seen;
	string cur_test = "reset_idle";

	gc_top dut0 (.*);

	initial begin
		clk = 0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xs_next(input logic [31:0] s);
		logic [31:0] t;
		t = s ^ (s << 13);
		t = t ^ (t >> 17);
		t = t ^ (t << 5);
		return t;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed_var)) % (hi - lo + 1));
	endfunction

	// Expected stream: R, then input labels, then the output mask
	function automatic void build_expected(input logic [31:0] s);
		logic [31:0] st;
		logic [31:0] r;
		logic [31:0] m;
		logic [31:0] lbl [256];
		int w;
		st = xs_next(s);
		r = st | 32'd1;
		exp_tag.push_back(TAG_KEYS);
		exp_idx.push_back('0);
		exp_data.push_back(r);
		for (int i = 0; i < n_in; i++) begin
			st = xs_next(st);
			lbl[i] = st;
			exp_tag.push_back(TAG_INPUT);
			exp_idx.push_back(WIRE_W'(i));
			exp_data.push_back(st);
		end
		for (int g = 0; g < n_gates; g++) begin
			w = n_in + g;
			case (tb_op[g])
				GATE_XNOR: lbl[w] = lbl[tb_in0[g]] ^ lbl[tb_in1[g]] ^ r;
				GATE_NOT: lbl[w] = lbl[tb_in0[g]] ^ r;
				default: lbl[w] = lbl[tb_in0[g]] ^ lbl[tb_in1[g]];
			endcase
		end
		m = '0;
		for (int i = 0; i < n_out; i++)
			m[i] = lbl[n_in + n_gates - n_out + i][0];
		exp_tag.push_back(TAG_MASK);
		exp_idx.push_back('0);
		exp_data.push_back(m);
	endfunction

	// Stream monitor, samples on the falling edge where outputs are stable
	always @(negedge clk) begin
		if (!rst && tag != TAG_NONE) begin
			word_count++;
			if (exp_tag.size() == 0) begin
				$display("%s: unexpected %s word at index %0d", cur_test, tag.name(), index);
				err_count++;
			end else begin
				if (tag != exp_tag[0]) begin
					$display("%s: wrong tag order, expected a %s word but got %s",
						cur_test, exp_tag[0].name(), tag.name());
					err_count++;
				end else begin
					if (index !== exp_idx[0]) begin
						$display("[FAIL] %s %s index expected %0d actual %0d",
							cur_test, tag.name(), exp_idx[0], index);
						err_count++;
					end
					if (data !== exp_data[0]) begin
						$display("[FAIL] %s %s data expected %h actual %h",
							cur_test, tag.name(), exp_data[0], data);
						err_count++;
					end
				end
				void'(exp_tag.pop_front());
				void'(exp_idx.pop_front());
				void'(exp_data.pop_front());
			end
			if (tag == TAG_MASK) begin
				mask_seen = 1;
				if (busy !== 1'b0) begin
					$display("%s: busy still high with the mask word", cur_test);
					err_count++;
				end
			end
		end
	end

	initial begin
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("timeout in %s after %0d cycles, stream did not finish", cur_test, cycles);
				$display("ERRORS FOUND");
				$finish;
			end
		end
	end

	task automatic load_netlist();
		cfg_wr_en = 1;
		cfg_addr = CFG_INPUTS;
		cfg_data = WIRE_W'(n_in);
		@(posedge clk); #1;
		cfg_addr = CFG_GATES;
		cfg_data = WIRE_W'(n_gates);
		@(posedge clk); #1;
		cfg_addr = CFG_OUTPUTS;
		cfg_data = WIRE_W'(n_out);
		@(posedge clk); #1;
		cfg_wr_en = 0;
		for (int g = 0; g < n_gates; g++) begin
			nl_wr_en = 1;
			nl_wr_addr = GATE_W'(g);
			nl_wr_op = tb_op[g];
			nl_wr_in0 = WIRE_W'(tb_in0[g]);
			nl_wr_in1 = WIRE_W'(tb_in1[g]);
			@(posedge clk); #1;
		end
		nl_wr_en = 0;
	endtask

	task automatic random_netlist();
		n_in = rand_range(1, 32);
		n_gates = rand_range(1, 64);
		n_out = rand_range(1, (n_gates < 32) ? n_gates : 32);
		for (int g = 0; g < n_gates; g++) begin
			tb_op[g] = gate_op_t'(rand_range(0, 2));
			tb_in0[g] = rand_range(0, n_in + g - 1);
			tb_in1[g] = rand_range(0, n_in + g - 1);
		end
	endtask

	task automatic run_stream(input string name, input logic [31:0] s, input bit poke_busy);
		int errs_before;
		errs_before = err_count;
		cur_test = name;
		mask_seen = 0;
		build_expected(s);
		seed = s;
		start = 1;
		@(posedge clk); #1;
		start = 0;
		if (poke_busy) begin // This start lands while busy and must be ignored
			if (busy !== 1'b1) begin
				$display("%s: busy low right after start", name);
				err_count++;
			end
			seed = s ^ 32'h5a5a_a5a5;
			start = 1;
			@(posedge clk); #1;
			start = 0;
			seed = s;
		end
		while (!mask_seen) begin
			@(posedge clk); #1;
		end
		@(posedge clk); #1;
		if (exp_tag.size() != 0) begin
			$display("%s: %0d expected words were never received", name, exp_tag.size());
			err_count++;
		end
		if (busy !== 1'b0) begin
			$display("%s: busy did not fall after the mask word", name);
			err_count++;
		end
		test_count++;
		$display("test %s done, %0d errors", name, err_count - errs_before);
	endtask

	initial begin
		rst = 1;
		start = 0;
		seed = '0;
		cfg_wr_en = 0;
		cfg_addr = '0;
		cfg_data = '0;
		nl_wr_en = 0;
		nl_wr_addr = '0;
		nl_wr_op = GATE_XOR;
		nl_wr_in0 = '0;
		nl_wr_in1 = '0;
		repeat (2) @(posedge clk);
		#1 rst = 0;

		repeat (3) @(posedge clk);
		#1;
		if (busy !== 1'b0) begin
			$display("reset_idle: busy high after reset");
			err_count++;
		end
		test_count++;
		$display("test reset_idle done, %0d errors", err_count);

		n_in = 4; // XOR chain, gate g reads wire g and the wire just below it
		n_gates = 6;
		n_out = 3;
		for (int g = 0; g < n_gates; g++) begin
			tb_op[g] = GATE_XOR;
			tb_in0[g] = g;
			tb_in1[g] = n_in + g - 1;
		end
		load_netlist();
		run_stream("xor_only", 32'h1234_5678, 0);

		random_netlist();
		load_netlist();
		run_stream("random_mix", $random(seed_var) | 32'd1, 0);

		random_netlist();
		load_netlist();
		run_stream("rerun_busy_start", $random(seed_var) | 32'd2, 1);

		$display("tests %0d, words %0d, errors %0d", test_count, word_count, err_count);
		if (err_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- gc_top.sv
// Top of the garbling engine. Host loads sizes and netlist, pulses start
// with a seed, then takes the tagged label stream from tag, index and data.
`timescale 1ns/10ps

module gc_top import gc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [LABEL_W-1:0] seed,
	input logic cfg_wr_en,
	input logic [1:0] cfg_addr,
	input logic [WIRE_W-1:0] cfg_data,
	input logic nl_wr_en,
	input logic [GATE_W-1:0] nl_wr_addr,
	input gate_op_t nl_wr_op,
	input logic [WIRE_W-1:0] nl_wr_in0,
	input logic [WIRE_W-1:0] nl_wr_in1,
	output logic busy,
	output tag_t tag,
	output logic [WIRE_W-1:0] index,
	output logic [LABEL_W-1:0] data
);

	logic [WIRE_W-1:0] input_size, gate_size, output_size;
	logic nl_wr_ok;
	logic gen_load, gen_adv;
	logic [LABEL_W-1:0] gen_word;
	logic [GATE_W-1:0] gate_addr;
	gate_op_t gate_op;
	logic [WIRE_W-1:0] gate_in0, gate_in1;
	logic [WIRE_W-1:0] rd_addr0, rd_addr1;
	logic [LABEL_W-1:0] rd_data0, rd_data1;
	logic wr_en;
	logic [WIRE_W-1:0] wr_addr;
	logic [LABEL_W-1:0] wr_data;

	assign nl_wr_ok = nl_wr_en && !busy; // Netlist frozen during a run

	gc_config config0 (
		.clk(clk), .rst(rst),
		.cfg_wr_en(cfg_wr_en), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.busy(busy),
		.input_size(input_size), .gate_size(gate_size), .output_size(output_size)
	);

	netlist_store netlist0 (
		.clk(clk), .rst(rst),
		.nl_wr_en(nl_wr_ok), .nl_wr_addr(nl_wr_addr), .nl_wr_op(nl_wr_op),
		.nl_wr_in0(nl_wr_in0), .nl_wr_in1(nl_wr_in1),
		.gate_addr(gate_addr), .gate_op(gate_op),
		.gate_in0(gate_in0), .gate_in1(gate_in1)
	);

	label_gen gen0 (
		.clk(clk), .rst(rst),
		.gen_load(gen_load), .seed(seed), .gen_adv(gen_adv), .gen_word(gen_word)
	);

	label_ram labels0 (
		.clk(clk),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr0(rd_addr0), .rd_addr1(rd_addr1),
		.rd_data0(rd_data0), .rd_data1(rd_data1)
	);

	garble_ctrl ctrl0 (
		.clk(clk), .rst(rst), .start(start),
		.input_size(input_size), .gate_size(gate_size), .output_size(output_size),
		.gen_load(gen_load), .gen_adv(gen_adv), .gen_word(gen_word),
		.gate_addr(gate_addr), .gate_op(gate_op),
		.gate_in0(gate_in0), .gate_in1(gate_in1),
		.rd_addr0(rd_addr0), .rd_addr1(rd_addr1),
		.rd_data0(rd_data0), .rd_data1(rd_data1),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.busy(busy), .tag(tag), .index(index), .data(data)
	);

endmodule

//--- garble_ctrl.sv
// Garbling sequencer: emits R, generates input labels, walks the gates with
// free XOR and collects the output mask. One gate every three cycles.
`timescale 1ns/10ps

module garble_ctrl import gc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [WIRE_W-1:0] input_size,
	input logic [WIRE_W-1:0] gate_size,
	input logic [WIRE_W-1:0] output_size,
	output logic gen_load,
	output logic gen_adv,
	input logic [LABEL_W-1:0] gen_word,
	output logic [GATE_W-1:0] gate_addr,
	input gate_op_t gate_op,
	input logic [WIRE_W-1:0] gate_in0,
	input logic [WIRE_W-1:0] gate_in1,
	output logic [WIRE_W-1:0] rd_addr0,
	output logic [WIRE_W-1:0] rd_addr1,
	input logic [LABEL_W-1:0] rd_data0,
	input logic [LABEL_W-1:0] rd_data1,
	output logic wr_en,
	output logic [WIRE_W-1:0] wr_addr,
	output logic [LABEL_W-1:0] wr_data,
	output logic busy,
	output tag_t tag,
	output logic [WIRE_W-1:0] index,
	output logic [LABEL_W-1:0] data
);

	ctrl_state_t state, state_nxt;
	logic accept;
	logic [LABEL_W-1:0] r_key;     // Global offset
	logic [LABEL_W-1:0] r_new;
	logic [LABEL_W-1:0] gate_label;
	logic [LABEL_W-1:0] mask;
	logic [WIRE_W-1:0] wire_cnt;   // Next wire to be labelled
	logic [WIRE_W-1:0] gate_cnt;
	logic [WIRE_W-1:0] first_out;
	logic [WIRE_W-1:0] out_idx;
	logic is_out, last_input, last_gate;

	assign busy = !(state == IDLE || state == DONE);
	assign accept = start && !busy;
	assign gen_load = accept;
	assign gen_adv = (state == KEYS) || (state == INLABELS);
	assign r_new = {gen_word[LABEL_W-1:1], 1'b1}; // Point-and-permute bit

	assign gate_addr = gate_cnt[GATE_W-1:0];
	assign rd_addr0 = gate_in0; // Operands valid in GATE_READ
	assign rd_addr1 = gate_in1;

	// Outputs are the last output_size gate wires
	assign first_out = gate_size - output_size;
	assign out_idx = gate_cnt - first_out;
	assign is_out = gate_cnt >= first_out;
	assign last_input = wire_cnt == input_size - 1'b1;
	assign last_gate = gate_cnt == gate_size - 1'b1;

	always_comb begin
		case (gate_op)
			GATE_XNOR: gate_label = rd_data0 ^ rd_data1 ^ r_key;
			GATE_NOT: gate_label = rd_data0 ^ r_key;
			default: gate_label = rd_data0 ^ rd_data1;
		endcase
	end

	// Input labels and gate labels share the running wire counter
	assign wr_en = (state == INLABELS) || (state == GATE_WRITE);
	assign wr_addr = wire_cnt;
	assign wr_data = (state == INLABELS) ? gen_word : gate_label;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE, DONE: if (accept) state_nxt = KEYS;
			KEYS: begin
				if (input_size != '0)
					state_nxt = INLABELS;
				else if (gate_size != '0)
					state_nxt = GATE_FETCH;
				else
					state_nxt = MASK;
			end
			INLABELS: begin
				if (last_input)
					state_nxt = (gate_size != '0) ? GATE_FETCH : MASK;
			end
			GATE_FETCH: state_nxt = GATE_READ;
			GATE_READ: state_nxt = GATE_WRITE;
			GATE_WRITE: state_nxt = last_gate ? MASK : GATE_FETCH;
			MASK: state_nxt = DONE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			r_key <= '0;
			wire_cnt <= '0;
			gate_cnt <= '0;
			mask <= '0;
		end else begin
			state <= state_nxt;
			if (accept) begin
				wire_cnt <= '0;
				gate_cnt <= '0;
				mask <= '0;
			end
			if (state == KEYS)
				r_key <= r_new;
			if (wr_en)
				wire_cnt <= wire_cnt + 1'b1;
			if (state == GATE_WRITE) begin
				gate_cnt <= gate_cnt + 1'b1;
				if (is_out)
					mask[out_idx[MASK_IDX_W-1:0]] <= gate_label[0];
			end
		end
	end

	// Registered stream port
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tag <= TAG_NONE;
			index <= '0;
			data <= '0;
		end else begin
			tag <= TAG_NONE;
			case (state)
				KEYS: begin
					tag <= TAG_KEYS;
					index <= '0;
					data <= r_new;
				end
				INLABELS: begin
					tag <= TAG_INPUT;
					index <= wire_cnt;
					data <= gen_word;
				end
				MASK: begin
					tag <= TAG_MASK;
					index <= '0;
					data <= mask;
				end
				default: ;
			endcase
		end
	end

	// Only the mask word may appear once busy has dropped
	a_quiet_when_idle: assert property (@(posedge clk) disable iff (rst)
		!busy && $past(state) != MASK |-> tag == TAG_NONE)
		else $error("stream word emitted while idle");

	// A NOT label must flip the permute bit of its input, which needs R[0] set
	a_r_lsb: assert property (@(posedge clk) disable iff (rst)
		state == GATE_WRITE && gate_op == GATE_NOT |-> gate_label[0] != rd_data0[0])
		else $error("R lowest bit is not set");

endmodule

//--- label_ram.sv
// Wire label memory, one label per wire.
// One write port and two read ports with registered data.
`timescale 1ns/10ps

module label_ram import gc_pkg::*; (
	input logic clk,
	input logic wr_en,
	input logic [WIRE_W-1:0] wr_addr,
	input logic [LABEL_W-1:0] wr_data,
	input logic [WIRE_W-1:0] rd_addr0,
	input logic [WIRE_W-1:0] rd_addr1,
	output logic [LABEL_W-1:0] rd_data0,
	output logic [LABEL_W-1:0] rd_data1
);

	logic [LABEL_W-1:0] mem [2**WIRE_W];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Both operands of a gate are read in the same cycle
	always_ff @(posedge clk) begin
		rd_data0 <= mem[rd_addr0];
		rd_data1 <= mem[rd_addr1];
	end

endmodule

//--- label_gen.sv
// Xorshift32 label source. Load a seed, then each advance moves the state
// to the word shown on gen_word in that same cycle.
`timescale 1ns/10ps

module label_gen import gc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic gen_load,
	input logic [LABEL_W-1:0] seed,
	input logic gen_adv,
	output logic [LABEL_W-1:0] gen_word
);

	logic [LABEL_W-1:0] xs_state;
	logic [LABEL_W-1:0] step1, step2;

	always_comb begin
		step1 = xs_state ^ (xs_state << 13);
		step2 = step1 ^ (step1 >> 17);
		gen_word = step2 ^ (step2 << 5); // Next state, used this cycle
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			xs_state <= '0;
		else if (gen_load)
			xs_state <= seed;
		else if (gen_adv)
			xs_state <= gen_word;
	end

	// A zero state would lock the generator at zero
	a_seed_nonzero: assert property (@(posedge clk) disable iff (rst)
		gen_load |=> xs_state != '0)
		else $error("label generator loaded with a zero state");

endmodule

//--- netlist_store.sv
// Gate netlist memory. The host writes one gate per cycle, the controller
// reads one gate per address with a single cycle of latency.
`timescale 1ns/10ps

module netlist_store import gc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic nl_wr_en,
	input logic [GATE_W-1:0] nl_wr_addr,
	input gate_op_t nl_wr_op,
	input logic [WIRE_W-1:0] nl_wr_in0,
	input logic [WIRE_W-1:0] nl_wr_in1,
	input logic [GATE_W-1:0] gate_addr,
	output gate_op_t gate_op,
	output logic [WIRE_W-1:0] gate_in0,
	output logic [WIRE_W-1:0] gate_in1
);

	gate_op_t op_mem [2**GATE_W];
	logic [WIRE_W-1:0] in0_mem [2**GATE_W];
	logic [WIRE_W-1:0] in1_mem [2**GATE_W];

	always_ff @(posedge clk) begin
		if (nl_wr_en) begin
			op_mem[nl_wr_addr] <= nl_wr_op;
			in0_mem[nl_wr_addr] <= nl_wr_in0;
			in1_mem[nl_wr_addr] <= nl_wr_in1;
		end
	end

	// Registered read, held while gate_addr is stable
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			gate_op <= GATE_XOR;
			gate_in0 <= '0;
			gate_in1 <= '0;
		end else begin
			gate_op <= op_mem[gate_addr];
			gate_in0 <= in0_mem[gate_addr];
			gate_in1 <= in1_mem[gate_addr];
		end
	end

endmodule

//--- gc_config.sv
// Size registers for the netlist: inputs, gates and outputs.
// Written by the host while the engine is not busy, read by the controller.
`timescale 1ns/10ps

module gc_config import gc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cfg_wr_en,
	input logic [1:0] cfg_addr,
	input logic [WIRE_W-1:0] cfg_data,
	input logic busy,
	output logic [WIRE_W-1:0] input_size,
	output logic [WIRE_W-1:0] gate_size,
	output logic [WIRE_W-1:0] output_size
);

	logic wr_ok;
	logic [WIRE_W:0] wire_total;

	assign wr_ok = cfg_wr_en && !busy; // Sizes frozen during a run
	assign wire_total = {1'b0, input_size} + {1'b0, gate_size};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			input_size <= '0;
			gate_size <= '0;
			output_size <= '0;
		end else if (wr_ok) begin
			case (cfg_addr)
				CFG_INPUTS: input_size <= cfg_data;
				CFG_GATES: gate_size <= cfg_data;
				CFG_OUTPUTS: output_size <= cfg_data;
				default: ;
			endcase
		end
	end

	// Limits sampled on the cycle the controller leaves IDLE or DONE
	a_out_le_gates: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> output_size <= gate_size)
		else $error("output_size exceeds gate_size");

	a_out_le_mask: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> output_size <= LABEL_W)
		else $error("output_size does not fit the mask word");

	a_wires_fit: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> wire_total <= (1 << WIRE_W))
		else $error("input_size + gate_size exceeds wire space");

endmodule

//--- gc_pkg.sv
// Shared widths, stream tags, gate opcodes and config register map
// for the free-XOR garbling engine. Every design module imports it.
package gc_pkg;

	localparam int LABEL_W = 32; // One label word
	localparam int WIRE_W = 8;   // Up to 256 wires
	localparam int GATE_W = 7;   // Up to 128 gates
	localparam int MASK_IDX_W = $clog2(LABEL_W);

	// Host config register addresses
	localparam logic [1:0] CFG_INPUTS = 2'd0;
	localparam logic [1:0] CFG_GATES = 2'd1;
	localparam logic [1:0] CFG_OUTPUTS = 2'd2;

	typedef enum logic [1:0] {
		GATE_XOR = 2'd0,
		GATE_XNOR = 2'd1,
		GATE_NOT = 2'd2
	} gate_op_t;

	// Stream tags, same codes as the two-lane engine
	typedef enum logic [2:0] {
		TAG_NONE = 3'b000,
		TAG_KEYS = 3'b001,
		TAG_MASK = 3'b011,
		TAG_INPUT = 3'b101
	} tag_t;

	typedef enum logic [2:0] {
		IDLE,
		KEYS,
		INLABELS,
		GATE_FETCH,
		GATE_READ,
		GATE_WRITE,
		MASK,
		DONE
	} ctrl_state_t;

endpackage
